//--- dv/decodeStageTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module decodeStageTb;
	import decodePkg::*;

	localparam int numInstr    = 2000;
	localparam int resetCycles = 8;
	localparam int cycleLimit  = numInstr + 2 * resetCycles + 50;

	typedef struct packed {
		word    rd1;
		word    rd2;
		word    rd3;
		word    extImm;
		regAddr writeAddr;
		cond    condField;
		flags   flagsOut;
		aluCtrl aluControl;
		logic   regWrite;
		logic   memToReg;
		logic   branch;
		logic   pcSrc;
		logic   aluSrc;
	} expBundle;

	logic   clk;
	logic   rstN;
	logic   regWriteW;
	word    instruction;
	word    resultW;
	word    pcPlus8;
	regAddr writeAddrW;
	flags   flagsIn;
	word    rd1E;
	word    rd2E;
	word    rd3E;
	word    extImmE;
	regAddr writeAddrE;
	cond    condE;
	flags   flagsE;
	aluCtrl aluControlE;
	logic   regWriteE;
	logic   memToRegE;
	logic   branchE;
	logic   pcSrcE;
	logic   aluSrcE;

	expBundle    expQ[$];
	word         model [`REG_COUNT];
	logic [31:0] rngState   = 32'hd3da;
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;

	tbClock tbClock_i (
		.clk (clk)
	);

	decodeStage decodeStage_i (
		.clk         (clk),
		.rstN        (rstN),
		.regWriteW   (regWriteW),
		.instruction (instruction),
		.resultW     (resultW),
		.pcPlus8     (pcPlus8),
		.writeAddrW  (writeAddrW),
		.flagsIn     (flagsIn),
		.rd1E        (rd1E),
		.rd2E        (rd2E),
		.rd3E        (rd3E),
		.extImmE     (extImmE),
		.writeAddrE  (writeAddrE),
		.condE       (condE),
		.flagsE      (flagsE),
		.aluControlE (aluControlE),
		.regWriteE   (regWriteE),
		.memToRegE   (memToRegE),
		.branchE     (branchE),
		.pcSrcE      (pcSrcE),
		.aluSrcE     (aluSrcE)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Legal classes get most of the draws, opcode 11 the rest.
	function automatic word makeInstr();
		word raw;
		word sel;
		raw = nextRand();
		sel = nextRand();
		if (sel[3:0] < 4'd6) begin
			raw[27:26] = 2'b00;
		end else if (sel[3:0] < 4'd10) begin
			raw[27:26] = 2'b01;
		end else if (sel[3:0] < 4'd14) begin
			raw[27:26] = 2'b10;
		end else begin
			raw[27:26] = 2'b11;
		end
		return raw;
	endfunction

	// r15 is the PC; otherwise a same-cycle writeback wins over the stored value.
	function automatic word modelRead(input regAddr a, input word pc8, input logic wbEn,
		input regAddr wbAddr, input word wbData);
		if (a == 4'd15) begin
			return pc8;
		end
		if (wbEn && (a == wbAddr)) begin
			return wbData;
		end
		return model[a];
	endfunction

	function automatic expBundle decodeRef(input word instr, input word pc8, input flags fl,
		input logic wbEn, input regAddr wbAddr, input word wbData);
		expBundle   e;
		logic [3:0] cmd;
		logic [1:0] fmt;
		regAddr     a1;
		regAddr     a2;
		e   = '0;
		cmd = instr[24:21];
		fmt = 2'b00;
		a1  = instr[19:16];
		a2  = instr[3:0];
		case (instr[27:26])
			2'b00: begin
				e.aluSrc   = instr[25];
				e.regWrite = 1'b1;
				case (cmd)
					4'b0100, 4'b0010, 4'b0000, 4'b1100, 4'b1101: e.aluControl = cmd;
					4'b1010: begin
						e.aluControl = cmd;
						e.regWrite   = 1'b0;
					end
					default: begin
						e.aluControl = 4'b0100;
						e.regWrite   = 1'b0;
					end
				endcase
			end
			2'b01: begin
				e.aluControl = 4'b0100;
				e.aluSrc     = 1'b1;
				e.regWrite   = instr[20];
				e.memToReg   = instr[20];
				fmt          = 2'b01;
				if (!instr[20]) begin
					a2 = instr[15:12];
				end
			end
			2'b10: begin
				e.branch     = 1'b1;
				e.aluControl = 4'b0100;
				e.aluSrc     = 1'b1;
				fmt          = 2'b10;
				a1           = 4'd15;
			end
			default: ;
		endcase
		case (fmt)
			2'b00: e.extImm = {24'b0, instr[7:0]};
			2'b01: e.extImm = {20'b0, instr[11:0]};
			default: e.extImm = {{8{instr[23]}}, instr[23:0]} << 2;
		endcase
		e.pcSrc     = e.branch | (e.regWrite && (instr[15:12] == 4'd15));
		e.rd1       = modelRead(a1, pc8, wbEn, wbAddr, wbData);
		e.rd2       = modelRead(a2, pc8, wbEn, wbAddr, wbData);
		e.rd3       = modelRead(instr[11:8], pc8, wbEn, wbAddr, wbData);
		e.writeAddr = instr[15:12];
		e.condField = instr[31:28];
		e.flagsOut  = fl;
		return e;
	endfunction

	task automatic checkWord(input string name, input word exp, input word act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic checkAddr(input string name, input regAddr exp, input regAddr act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic checkCond(input string name, input cond exp, input cond act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic checkFlags(input string name, input flags exp, input flags act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic checkAlu(input string name, input aluCtrl exp, input aluCtrl act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, exp, act);
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("MISMATCH t=%0t %s expected=%b actual=%b", $time, name, exp, act);
		end
	endtask

	// Records what the DUT sampled at this edge, then drives the next cycle.
	task automatic driveCycle(input logic rstLevel);
		expBundle e;
		word      wb;
		@(posedge clk);
		if (!rstN) begin
			e = '0;
		end else begin
			e = decodeRef(instruction, pcPlus8, flagsIn, regWriteW, writeAddrW, resultW);
		end
		expQ.push_back(e);
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				model[i] = '0;
			end
		end else if (regWriteW && (writeAddrW != 4'd15)) begin
			model[writeAddrW] = resultW;
		end
		wb = nextRand();
		rstN        <= rstLevel;
		regWriteW   <= wb[0] | wb[1];
		writeAddrW  <= wb[7:4];
		flagsIn     <= wb[11:8];
		resultW     <= nextRand();
		pcPlus8     <= nextRand();
		instruction <= makeInstr();
	endtask

	always @(negedge clk) begin : compareOutputs
		expBundle e;
		if (expQ.size() > 0) begin
			e = expQ.pop_front();
			checkWord("rd1E", e.rd1, rd1E);
			checkWord("rd2E", e.rd2, rd2E);
			checkWord("rd3E", e.rd3, rd3E);
			checkWord("extImmE", e.extImm, extImmE);
			checkAddr("writeAddrE", e.writeAddr, writeAddrE);
			checkCond("condE", e.condField, condE);
			checkFlags("flagsE", e.flagsOut, flagsE);
			checkAlu("aluControlE", e.aluControl, aluControlE);
			checkBit("regWriteE", e.regWrite, regWriteE);
			checkBit("memToRegE", e.memToReg, memToRegE);
			checkBit("branchE", e.branch, branchE);
			checkBit("pcSrcE", e.pcSrc, pcSrcE);
			checkBit("aluSrcE", e.aluSrc, aluSrcE);
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		rstN        <= 1'b0;
		regWriteW   <= 1'b0;
		instruction <= '0;
		resultW     <= '0;
		pcPlus8     <= '0;
		writeAddrW  <= '0;
		flagsIn     <= '0;
		repeat (resetCycles - 1) driveCycle(1'b0);
		repeat (numInstr / 2) driveCycle(1'b1);
		// A second reset must wipe the registers written so far.
		repeat (resetCycles) driveCycle(1'b0);
		repeat (numInstr / 2) driveCycle(1'b1);
		driveCycle(1'b1);
		@(negedge clk);
		@(negedge clk);
		if (expQ.size() != 0) begin
			errorCount++;
			$display("Some expected results were never compared");
		end
		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/decodeStage_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStageAsserts (
	input logic              clk,
	input logic              rstN,
	input logic              regWriteE,
	input logic              memToRegE,
	input logic              branchE,
	input logic              pcSrcE,
	input logic              aluSrcE,
	input decodePkg::aluCtrl aluControlE
);

	// The first cycle out of reset still shows the bubble.
	resetBubble: assert property (@(posedge clk)
		$rose(rstN) |-> !(regWriteE | memToRegE | branchE | pcSrcE | aluSrcE)
			&& (aluControlE == 4'b0000))
		else $error("control outputs not cleared in the cycle after reset");

	branchRedirects: assert property (@(posedge clk) disable iff (!rstN)
		branchE |-> pcSrcE)
		else $error("branchE set without pcSrcE");

	loadWrites: assert property (@(posedge clk) disable iff (!rstN)
		memToRegE |-> regWriteE)
		else $error("memToRegE set without regWriteE");

endmodule

bind decodeStage decodeStageAsserts decodeStageAsserts_i (
	.clk         (clk),
	.rstN        (rstN),
	.regWriteE   (regWriteE),
	.memToRegE   (memToRegE),
	.branchE     (branchE),
	.pcSrcE      (pcSrcE),
	.aluSrcE     (aluSrcE),
	.aluControlE (aluControlE)
);

`default_nettype wire

//--- dv/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
	output logic clk
);

	// 4 ns period.
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module controlUnit (
	input  decodePkg::opcode  opcode,
	input  logic [5:0]        funct,
	input  decodePkg::regAddr rd,
	output logic              aluSrc,
	output decodePkg::aluCtrl aluControl,
	output logic              memToReg,
	output logic [1:0]        regSrc,
	output decodePkg::immSrc  immSel,
	output logic              regWrite,
	output logic              branch,
	output logic              pcSrc
);
	import decodePkg::*;

	aluCtrl dpAlu;
	logic   dpWrite;

	// ALU decoder on the command field in funct[4:1].
	always_comb begin
		dpWrite = 1'b1;
		case (funct[4:1])
			aluAdd: dpAlu = aluAdd;
			aluSub: dpAlu = aluSub;
			aluAnd: dpAlu = aluAnd;
			aluOrr: dpAlu = aluOrr;
			aluMov: dpAlu = aluMov;
			aluCmp: begin
				dpAlu   = aluCmp;
				dpWrite = 1'b0;
			end
			default: begin
				dpAlu   = aluAdd;
				dpWrite = 1'b0;
			end
		endcase
	end

	// Main decoder.
	always_comb begin
		aluSrc     = 1'b0;
		aluControl = '0;
		memToReg   = 1'b0;
		regSrc     = 2'b00;
		immSel     = '0;
		regWrite   = 1'b0;
		branch     = 1'b0;
		case (opcode)
			opData: begin
				aluSrc     = funct[5];
				aluControl = dpAlu;
				immSel     = immDp8;
				regWrite   = dpWrite;
			end
			opMem: begin
				aluSrc     = 1'b1;
				aluControl = aluAdd;
				immSel     = immMem12;
				memToReg   = funct[0];
				regWrite   = funct[0];
				// A store needs Rd on the second read port.
				regSrc[1]  = ~funct[0];
			end
			opBranch: begin
				aluSrc     = 1'b1;
				aluControl = aluAdd;
				immSel     = immBranch;
				branch     = 1'b1;
				regSrc[0]  = 1'b1;
			end
			default: ;
		endcase
	end

	// Writing r15 redirects the PC just like a branch.
	assign pcSrc = branch | (regWrite & (rd == regAddr'(`PC_REG)));

endmodule

`default_nettype wire

//--- hdl/decodePkg.sv
`default_nettype none

`include "decode_defs.svh"

package decodePkg;

	typedef logic [`DATA_WIDTH-1:0]     word;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;
	typedef logic [3:0]                 cond;
	typedef logic [3:0]                 flags;
	typedef logic [3:0]                 aluCtrl;
	typedef logic [1:0]                 immSrc;
	typedef logic [1:0]                 opcode;

	// ALU operation codes shared with the execute stage.
	localparam aluCtrl aluAnd = 4'b0000;
	localparam aluCtrl aluSub = 4'b0010;
	localparam aluCtrl aluAdd = 4'b0100;
	localparam aluCtrl aluCmp = 4'b1010;
	localparam aluCtrl aluOrr = 4'b1100;
	localparam aluCtrl aluMov = 4'b1101;

	// Immediate formats.
	localparam immSrc immDp8     = 2'b00;
	localparam immSrc immMem12   = 2'b01;
	localparam immSrc immBranch  = 2'b10;

	// Instruction classes in bits 27..26.
	localparam opcode opData   = 2'b00;
	localparam opcode opMem    = 2'b01;
	localparam opcode opBranch = 2'b10;

endpackage

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module decodeStage (
	input  logic              clk,
	input  logic              rstN,
	input  logic              regWriteW,
	input  decodePkg::word    instruction,
	input  decodePkg::word    resultW,
	input  decodePkg::word    pcPlus8,
	input  decodePkg::regAddr writeAddrW,
	input  decodePkg::flags   flagsIn,
	output decodePkg::word    rd1E,
	output decodePkg::word    rd2E,
	output decodePkg::word    rd3E,
	output decodePkg::word    extImmE,
	output decodePkg::regAddr writeAddrE,
	output decodePkg::cond    condE,
	output decodePkg::flags   flagsE,
	output decodePkg::aluCtrl aluControlE,
	output logic              regWriteE,
	output logic              memToRegE,
	output logic              branchE,
	output logic              pcSrcE,
	output logic              aluSrcE
);
	import decodePkg::*;

	cond         condD;
	opcode       opD;
	logic [5:0]  functD;
	regAddr      rnD;
	regAddr      rdD;
	regAddr      rsD;
	regAddr      rmD;
	logic [23:0] immFieldD;

	regAddr      ra1D;
	regAddr      ra2D;

	logic        aluSrcD;
	aluCtrl      aluControlD;
	logic        memToRegD;
	logic [1:0]  regSrcD;
	immSrc       immSelD;
	logic        regWriteD;
	logic        branchD;
	logic        pcSrcD;

	word         rd1D;
	word         rd2D;
	word         rd3D;
	word         extImmD;

	// Instruction fields.
	assign condD     = instruction[31:28];
	assign opD       = instruction[27:26];
	assign functD    = instruction[25:20];
	assign rnD       = instruction[19:16];
	assign rdD       = instruction[15:12];
	assign rsD       = instruction[11:8];
	assign rmD       = instruction[3:0];
	assign immFieldD = instruction[23:0];

	// Branches read the PC on port 1, stores read Rd on port 2.
	assign ra1D = regSrcD[0] ? regAddr'(`PC_REG) : rnD;
	assign ra2D = regSrcD[1] ? rdD : rmD;

	controlUnit controlUnit_i (
		.opcode     (opD),
		.funct      (functD),
		.rd         (rdD),
		.aluSrc     (aluSrcD),
		.aluControl (aluControlD),
		.memToReg   (memToRegD),
		.regSrc     (regSrcD),
		.immSel     (immSelD),
		.regWrite   (regWriteD),
		.branch     (branchD),
		.pcSrc      (pcSrcD)
	);

	immExtend immExtend_i (
		.immField (immFieldD),
		.immSel   (immSelD),
		.extImm   (extImmD)
	);

	registerFile registerFile_i (
		.clk        (clk),
		.rstN       (rstN),
		.regWriteW  (regWriteW),
		.addr1      (ra1D),
		.addr2      (ra2D),
		.addr3      (rsD),
		.writeAddrW (writeAddrW),
		.resultW    (resultW),
		.pcPlus8    (pcPlus8),
		.rd1        (rd1D),
		.rd2        (rd2D),
		.rd3        (rd3D)
	);

	pipeDecoExe pipeDecoExe_i (
		.clk         (clk),
		.rstN        (rstN),
		.rd1D        (rd1D),
		.rd2D        (rd2D),
		.rd3D        (rd3D),
		.extImmD     (extImmD),
		.writeAddrD  (rdD),
		.condD       (condD),
		.flagsD      (flagsIn),
		.aluControlD (aluControlD),
		.regWriteD   (regWriteD),
		.memToRegD   (memToRegD),
		.branchD     (branchD),
		.pcSrcD      (pcSrcD),
		.aluSrcD     (aluSrcD),
		.rd1E        (rd1E),
		.rd2E        (rd2E),
		.rd3E        (rd3E),
		.extImmE     (extImmE),
		.writeAddrE  (writeAddrE),
		.condE       (condE),
		.flagsE      (flagsE),
		.aluControlE (aluControlE),
		.regWriteE   (regWriteE),
		.memToRegE   (memToRegE),
		.branchE     (branchE),
		.pcSrcE      (pcSrcE),
		.aluSrcE     (aluSrcE)
	);

endmodule

`default_nettype wire

//--- hdl/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Width of the data path, register contents and immediates.
`define DATA_WIDTH 32

// Width of a register index as encoded in the instruction.
`define REG_ADDR_WIDTH 4

// Registers actually stored in the register file.
`define REG_COUNT 15

// Index that reads back as PC+8 instead of a stored value.
`define PC_REG 15

`endif

//--- hdl/immExtend.sv
`timescale 1ns/100ps
`default_nettype none

module immExtend (
	input  logic [23:0]      immField,
	input  decodePkg::immSrc immSel,
	output decodePkg::word   extImm
);
	import decodePkg::*;

	always_comb begin
		case (immSel)
			immDp8: begin
				extImm = {24'b0, immField[7:0]};
			end
			immMem12: begin
				extImm = {20'b0, immField[11:0]};
			end
			immBranch: begin
				// The word offset is sign extended and scaled to bytes.
				extImm = {{6{immField[23]}}, immField, 2'b00};
			end
			default: begin
				extImm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/pipeDecoExe.sv
`timescale 1ns/100ps
`default_nettype none

module pipeDecoExe (
	input  logic              clk,
	input  logic              rstN,
	input  decodePkg::word    rd1D,
	input  decodePkg::word    rd2D,
	input  decodePkg::word    rd3D,
	input  decodePkg::word    extImmD,
	input  decodePkg::regAddr writeAddrD,
	input  decodePkg::cond    condD,
	input  decodePkg::flags   flagsD,
	input  decodePkg::aluCtrl aluControlD,
	input  logic              regWriteD,
	input  logic              memToRegD,
	input  logic              branchD,
	input  logic              pcSrcD,
	input  logic              aluSrcD,
	output decodePkg::word    rd1E,
	output decodePkg::word    rd2E,
	output decodePkg::word    rd3E,
	output decodePkg::word    extImmE,
	output decodePkg::regAddr writeAddrE,
	output decodePkg::cond    condE,
	output decodePkg::flags   flagsE,
	output decodePkg::aluCtrl aluControlE,
	output logic              regWriteE,
	output logic              memToRegE,
	output logic              branchE,
	output logic              pcSrcE,
	output logic              aluSrcE
);

	// Every field clears on reset so execute sees a bubble.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rd1E        <= '0;
			rd2E        <= '0;
			rd3E        <= '0;
			extImmE     <= '0;
			writeAddrE  <= '0;
			condE       <= '0;
			flagsE      <= '0;
			aluControlE <= '0;
			regWriteE   <= 1'b0;
			memToRegE   <= 1'b0;
			branchE     <= 1'b0;
			pcSrcE      <= 1'b0;
			aluSrcE     <= 1'b0;
		end else begin
			rd1E        <= rd1D;
			rd2E        <= rd2D;
			rd3E        <= rd3D;
			extImmE     <= extImmD;
			writeAddrE  <= writeAddrD;
			condE       <= condD;
			flagsE      <= flagsD;
			aluControlE <= aluControlD;
			regWriteE   <= regWriteD;
			memToRegE   <= memToRegD;
			branchE     <= branchD;
			pcSrcE      <= pcSrcD;
			aluSrcE     <= aluSrcD;
		end
	end

endmodule

`default_nettype wire

//--- hdl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_defs.svh"

module registerFile (
	input  logic              clk,
	input  logic              rstN,
	input  logic              regWriteW,
	input  decodePkg::regAddr addr1,
	input  decodePkg::regAddr addr2,
	input  decodePkg::regAddr addr3,
	input  decodePkg::regAddr writeAddrW,
	input  decodePkg::word    resultW,
	input  decodePkg::word    pcPlus8,
	output decodePkg::word    rd1,
	output decodePkg::word    rd2,
	output decodePkg::word    rd3
);
	import decodePkg::*;

	word regs [`REG_COUNT];

	// r15 is the PC, never the bypass value.
	function automatic word readPort(input regAddr addr);
		if (addr == regAddr'(`PC_REG)) begin
			return pcPlus8;
		end
		if (regWriteW && (addr == writeAddrW)) begin
			return resultW;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWriteW && (writeAddrW != regAddr'(`PC_REG))) begin
			regs[writeAddrW] <= resultW;
		end
	end

	// Reads follow the stored registers, the writeback port and PC+8.
	always_comb begin
		rd1 = readPort(addr1);
		rd2 = readPort(addr2);
		rd3 = readPort(addr3);
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f src.f --top-module decodeStageTb \
	-Mdir "$buildDir" -o simDecode
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simDecode" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$logFile"; then
	echo "Run result: fail"
	exit 1
fi
echo "Run result: pass"
exit 0

//--- src.f
+incdir+hdl
hdl/decodePkg.sv
hdl/controlUnit.sv
hdl/immExtend.sv
hdl/registerFile.sv
hdl/pipeDecoExe.sv
hdl/decodeStage.sv
dv/tbClock.sv
dv/decodeStage_asserts.sv
dv/decodeStageTb.sv
